// File: mips_types_pkg.sv
package mips_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mask_t;
    typedef logic [31:0] inst_addr_t;

    // Memory operation carried down from decode.
    typedef enum logic [3:0] {
        op_nop,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_sb,
        op_sh,
        op_sw
    } oper_t;

    typedef struct packed {
        logic       reg_we;
        reg_addr_t  reg_waddr;
        word_t      reg_wdata;
        logic       hilo_we;
        word_t      hi;
        word_t      lo;
        oper_t      oper;
        word_t      mem_addr;
        word_t      mem_wdata;
        logic       cp0_we;
        reg_addr_t  cp0_waddr;
        word_t      cp0_wdata;
        word_t      excp_req;
        inst_addr_t pc;
        logic       in_delayslot;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_we;
        reg_addr_t reg_waddr;
        word_t     reg_wdata;
        logic      hilo_we;
        word_t     hi;
        word_t     lo;
        logic      cp0_we;
        reg_addr_t cp0_waddr;
        word_t     cp0_wdata;
    } wb_t;

    // The data RAM holds 2**RAM_ADDR_BITS words.
    localparam int unsigned RAM_ADDR_BITS = 8;

endpackage

// File: mips_cp0_pkg.sv
package mips_cp0_pkg;

    localparam mips_types_pkg::reg_addr_t CP0_STATUS = 5'd12;
    localparam mips_types_pkg::reg_addr_t CP0_CAUSE  = 5'd13;
    localparam mips_types_pkg::reg_addr_t CP0_EPC    = 5'd14;

    localparam int unsigned STATUS_IE    = 0;
    localparam int unsigned STATUS_EXL   = 1;
    localparam int unsigned STATUS_IM_LO = 8;
    localparam int unsigned STATUS_IM_HI = 15;

    // IP[7:2] are the hardware lines and IP[1:0] the software ones.
    localparam int unsigned CAUSE_IP_LO    = 8;
    localparam int unsigned CAUSE_HW_IP_LO = 10;
    localparam int unsigned CAUSE_IP_HI    = 15;
    localparam int unsigned CAUSE_EXC_LO   = 2;
    localparam int unsigned CAUSE_EXC_HI   = 6;
    localparam int unsigned CAUSE_BD       = 31;

    localparam mips_types_pkg::word_t CAUSE_WRITE_MASK = 32'h0000_0300;

    // Bit positions in the exception request word from execute.
    localparam int unsigned REQ_SYSCALL = 8;
    localparam int unsigned REQ_INVALID = 9;
    localparam int unsigned REQ_OV      = 11;
    localparam int unsigned REQ_ERET    = 12;

    typedef logic [31:0] excp_t;

    localparam excp_t EXCP_NONE         = 32'd0;
    localparam excp_t EXCP_INTERRUPT    = 32'd1;
    localparam excp_t EXCP_SYSCALL      = 32'd8;
    localparam excp_t EXCP_INVALID_INST = 32'd10;
    localparam excp_t EXCP_OV           = 32'd12;
    localparam excp_t EXCP_ERET         = 32'd14;

    localparam mips_types_pkg::inst_addr_t PC_RESET_ADDR = 32'hBFC0_0000;

endpackage

// File: mem_stage.sv
module mem_stage (
    input  mips_types_pkg::ex_mem_t ex_mem_i,
    input  mips_types_pkg::word_t   ram_rdata_i,
    input  mips_types_pkg::word_t   cp0_status_i,
    input  mips_types_pkg::word_t   cp0_cause_i,
    input  mips_types_pkg::word_t   cp0_epc_i,
    input  mips_types_pkg::wb_t     wb_cp0_i,
    output mips_types_pkg::word_t   ram_addr_o,
    output mips_types_pkg::word_t   ram_wdata_o,
    output logic                    ram_we_o,
    output mips_types_pkg::mask_t   ram_mask_o,
    output mips_types_pkg::wb_t     wb_o,
    output mips_cp0_pkg::excp_t     excp_type_o,
    output mips_types_pkg::word_t   cp0_epc_o
);

    mips_types_pkg::word_t status_eff;
    mips_types_pkg::word_t cause_eff;
    mips_types_pkg::word_t epc_eff;
    mips_types_pkg::word_t load_data;
    logic [mips_cp0_pkg::STATUS_IM_HI-mips_cp0_pkg::STATUS_IM_LO:0] int_pending;
    logic int_taken;
    logic squash;
    logic is_load;
    logic mem_we;

    // A CP0 write sitting in writeback lands only at the next edge, so overlay it here.
    always_comb begin
        status_eff = cp0_status_i;
        cause_eff  = cp0_cause_i;
        epc_eff    = cp0_epc_i;
        if (wb_cp0_i.cp0_we) begin
            case (wb_cp0_i.cp0_waddr)
                mips_cp0_pkg::CP0_STATUS: status_eff = wb_cp0_i.cp0_wdata;
                mips_cp0_pkg::CP0_CAUSE: begin
                    cause_eff = (cp0_cause_i & ~mips_cp0_pkg::CAUSE_WRITE_MASK)
                              | (wb_cp0_i.cp0_wdata & mips_cp0_pkg::CAUSE_WRITE_MASK);
                end
                mips_cp0_pkg::CP0_EPC: epc_eff = wb_cp0_i.cp0_wdata;
                default: ;
            endcase
        end
    end

    assign cp0_epc_o = epc_eff;

    assign int_pending = cause_eff[mips_cp0_pkg::CAUSE_IP_HI:mips_cp0_pkg::CAUSE_IP_LO]
                       & status_eff[mips_cp0_pkg::STATUS_IM_HI:mips_cp0_pkg::STATUS_IM_LO];
    assign int_taken   = (|int_pending) && !status_eff[mips_cp0_pkg::STATUS_EXL]
                       && status_eff[mips_cp0_pkg::STATUS_IE];

    // Bubbles carry the reset PC and never raise anything.
    always_comb begin
        excp_type_o = mips_cp0_pkg::EXCP_NONE;
        if (ex_mem_i.pc != mips_cp0_pkg::PC_RESET_ADDR) begin
            if (int_taken) begin
                excp_type_o = mips_cp0_pkg::EXCP_INTERRUPT;
            end else if (ex_mem_i.excp_req[mips_cp0_pkg::REQ_SYSCALL]) begin
                excp_type_o = mips_cp0_pkg::EXCP_SYSCALL;
            end else if (ex_mem_i.excp_req[mips_cp0_pkg::REQ_INVALID]) begin
                excp_type_o = mips_cp0_pkg::EXCP_INVALID_INST;
            end else if (ex_mem_i.excp_req[mips_cp0_pkg::REQ_OV]) begin
                excp_type_o = mips_cp0_pkg::EXCP_OV;
            end else if (ex_mem_i.excp_req[mips_cp0_pkg::REQ_ERET]) begin
                excp_type_o = mips_cp0_pkg::EXCP_ERET;
            end
        end
    end

    assign squash = (excp_type_o != mips_cp0_pkg::EXCP_NONE);

    assign is_load = ex_mem_i.oper inside {mips_types_pkg::op_lb, mips_types_pkg::op_lbu,
                                           mips_types_pkg::op_lh, mips_types_pkg::op_lhu,
                                           mips_types_pkg::op_lw};

    // Sub-word accesses use the low byte lanes of the word.
    always_comb begin
        mem_we     = 1'b0;
        ram_mask_o = 4'b0000;
        load_data  = ram_rdata_i;
        case (ex_mem_i.oper)
            mips_types_pkg::op_lb: begin
                ram_mask_o = 4'b0001;
                load_data  = {{24{ram_rdata_i[7]}}, ram_rdata_i[7:0]};
            end
            mips_types_pkg::op_lbu: begin
                ram_mask_o = 4'b0001;
                load_data  = {24'b0, ram_rdata_i[7:0]};
            end
            mips_types_pkg::op_lh: begin
                ram_mask_o = 4'b0011;
                load_data  = {{16{ram_rdata_i[15]}}, ram_rdata_i[15:0]};
            end
            mips_types_pkg::op_lhu: begin
                ram_mask_o = 4'b0011;
                load_data  = {16'b0, ram_rdata_i[15:0]};
            end
            mips_types_pkg::op_lw: ram_mask_o = 4'b1111;
            mips_types_pkg::op_sb: begin
                mem_we     = 1'b1;
                ram_mask_o = 4'b0001;
            end
            mips_types_pkg::op_sh: begin
                mem_we     = 1'b1;
                ram_mask_o = 4'b0011;
            end
            mips_types_pkg::op_sw: begin
                mem_we     = 1'b1;
                ram_mask_o = 4'b1111;
            end
            default: ;
        endcase
    end

    assign ram_addr_o  = ex_mem_i.mem_addr;
    assign ram_wdata_o = ex_mem_i.mem_wdata;
    assign ram_we_o    = mem_we && !squash;

    always_comb begin
        wb_o.reg_we    = ex_mem_i.reg_we && !squash;
        wb_o.reg_waddr = ex_mem_i.reg_waddr;
        wb_o.reg_wdata = is_load ? load_data : ex_mem_i.reg_wdata;
        wb_o.hilo_we   = ex_mem_i.hilo_we && !squash;
        wb_o.hi        = ex_mem_i.hi;
        wb_o.lo        = ex_mem_i.lo;
        wb_o.cp0_we    = ex_mem_i.cp0_we && !squash;
        wb_o.cp0_waddr = ex_mem_i.cp0_waddr;
        wb_o.cp0_wdata = ex_mem_i.cp0_wdata;
    end

    always_comb begin
        assert (!(ram_we_o && is_load))
            else $error("mem_stage: RAM write enable raised during a load");
    end

endmodule

// File: cp0_regs.sv
module cp0_regs (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [5:0]                 hw_int_i,
    input  mips_cp0_pkg::excp_t        excp_type_i,
    input  mips_types_pkg::inst_addr_t pc_i,
    input  logic                       in_delayslot_i,
    input  mips_types_pkg::wb_t        wb_cp0_i,
    input  mips_types_pkg::reg_addr_t  raddr_i,
    output mips_types_pkg::word_t      rdata_o,
    output mips_types_pkg::word_t      status_o,
    output mips_types_pkg::word_t      cause_o,
    output mips_types_pkg::word_t      epc_o
);

    mips_types_pkg::word_t status_q;
    mips_types_pkg::word_t status_d;
    mips_types_pkg::word_t cause_q;
    mips_types_pkg::word_t cause_d;
    mips_types_pkg::word_t epc_q;
    mips_types_pkg::word_t epc_d;
    logic is_eret;
    logic excp_commit;

    assign is_eret     = (excp_type_i == mips_cp0_pkg::EXCP_ERET);
    assign excp_commit = (excp_type_i != mips_cp0_pkg::EXCP_NONE) && !is_eret;

    // The exception fields are assigned last so they win over a writeback write.
    always_comb begin
        status_d = status_q;
        cause_d  = cause_q;
        epc_d    = epc_q;
        if (wb_cp0_i.cp0_we) begin
            case (wb_cp0_i.cp0_waddr)
                mips_cp0_pkg::CP0_STATUS: status_d = wb_cp0_i.cp0_wdata;
                mips_cp0_pkg::CP0_CAUSE: begin
                    cause_d = (cause_q & ~mips_cp0_pkg::CAUSE_WRITE_MASK)
                            | (wb_cp0_i.cp0_wdata & mips_cp0_pkg::CAUSE_WRITE_MASK);
                end
                mips_cp0_pkg::CP0_EPC: epc_d = wb_cp0_i.cp0_wdata;
                default: ;
            endcase
        end
        cause_d[mips_cp0_pkg::CAUSE_IP_HI:mips_cp0_pkg::CAUSE_HW_IP_LO] = hw_int_i;
        if (excp_commit) begin
            status_d[mips_cp0_pkg::STATUS_EXL] = 1'b1;
            cause_d[mips_cp0_pkg::CAUSE_EXC_HI:mips_cp0_pkg::CAUSE_EXC_LO] =
                excp_type_i[mips_cp0_pkg::CAUSE_EXC_HI-mips_cp0_pkg::CAUSE_EXC_LO:0];
            cause_d[mips_cp0_pkg::CAUSE_BD] = in_delayslot_i;
            // A delay-slot instruction returns to its branch.
            epc_d = in_delayslot_i ? pc_i - 32'd4 : pc_i;
        end else if (is_eret) begin
            status_d[mips_cp0_pkg::STATUS_EXL] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            status_q <= status_d;
            cause_q  <= cause_d;
            epc_q    <= epc_d;
        end
    end

    assign status_o = status_q;
    assign cause_o  = cause_q;
    assign epc_o    = epc_q;

    always_comb begin
        case (raddr_i)
            mips_cp0_pkg::CP0_STATUS: rdata_o = status_q;
            mips_cp0_pkg::CP0_CAUSE:  rdata_o = cause_q;
            mips_cp0_pkg::CP0_EPC:    rdata_o = epc_q;
            default:                  rdata_o = '0;
        endcase
    end

    // Only a writeback write that clears EXL can let the stage take an interrupt.
    a_no_int_under_exl: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (status_q[mips_cp0_pkg::STATUS_EXL]
            && !(wb_cp0_i.cp0_we && wb_cp0_i.cp0_waddr == mips_cp0_pkg::CP0_STATUS))
        |-> (excp_type_i != mips_cp0_pkg::EXCP_INTERRUPT)
    );

endmodule

// File: data_ram.sv
module data_ram (
    input  logic                  clk,
    input  mips_types_pkg::word_t addr_i,
    input  mips_types_pkg::word_t wdata_i,
    input  logic                  we_i,
    input  mips_types_pkg::mask_t mask_i,
    output mips_types_pkg::word_t rdata_o
);

    mips_types_pkg::word_t mem [0:(1 << mips_types_pkg::RAM_ADDR_BITS)-1];
    logic [mips_types_pkg::RAM_ADDR_BITS-1:0] word_addr;

    // Byte offset bits are dropped, and the upper address bits wrap.
    assign word_addr = addr_i[mips_types_pkg::RAM_ADDR_BITS+1:2];

    assign rdata_o = mem[word_addr];

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mask_i[lane]) begin
                    mem[word_addr][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                end
            end
        end
    end

    a_we_has_lanes: assert property (
        @(posedge clk) we_i |-> (mask_i != 4'b0000)
    );

endmodule

// File: mem_wb_reg.sv
module mem_wb_reg (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_types_pkg::wb_t wb_i,
    output mips_types_pkg::wb_t wb_o
);

    mips_types_pkg::wb_t wb_q;

    // Only the write strobes are cleared on reset.
    always_ff @(posedge clk) begin
        wb_q <= wb_i;
        if (!rst_n_i) begin
            wb_q.reg_we  <= 1'b0;
            wb_q.hilo_we <= 1'b0;
            wb_q.cp0_we  <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

// File: mem_subsystem.sv
module mem_subsystem (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  mips_types_pkg::ex_mem_t   ex_mem_i,
    input  logic [5:0]                hw_int_i,
    input  mips_types_pkg::reg_addr_t cp0_raddr_i,
    output mips_types_pkg::wb_t       wb_o,
    output mips_cp0_pkg::excp_t       excp_type_o,
    output mips_types_pkg::word_t     cp0_epc_o,
    output mips_types_pkg::word_t     cp0_rdata_o
);

    mips_types_pkg::word_t ram_addr;
    mips_types_pkg::word_t ram_wdata;
    mips_types_pkg::word_t ram_rdata;
    mips_types_pkg::mask_t ram_mask;
    logic                  ram_we;
    mips_types_pkg::wb_t   stage_wb;
    mips_types_pkg::word_t cp0_status;
    mips_types_pkg::word_t cp0_cause;

    mem_stage u_mem_stage (
        .ex_mem_i     (ex_mem_i),
        .ram_rdata_i  (ram_rdata),
        .cp0_status_i (cp0_status),
        .cp0_cause_i  (cp0_cause),
        .cp0_epc_i    (cp0_epc_o),
        .wb_cp0_i     (wb_o),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .ram_we_o     (ram_we),
        .ram_mask_o   (ram_mask),
        .wb_o         (stage_wb),
        .excp_type_o  (excp_type_o),
        .cp0_epc_o    ()
    );

    cp0_regs u_cp0_regs (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .hw_int_i       (hw_int_i),
        .excp_type_i    (excp_type_o),
        .pc_i           (ex_mem_i.pc),
        .in_delayslot_i (ex_mem_i.in_delayslot),
        .wb_cp0_i       (wb_o),
        .raddr_i        (cp0_raddr_i),
        .rdata_o        (cp0_rdata_o),
        .status_o       (cp0_status),
        .cause_o        (cp0_cause),
        .epc_o          (cp0_epc_o)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .we_i    (ram_we),
        .mask_i  (ram_mask),
        .rdata_o (ram_rdata)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (stage_wb),
        .wb_o    (wb_o)
    );

endmodule

// File: tb_mem_subsystem.sv
module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int PRELOAD_WORDS = 16;
    localparam int NUM_RANDOM    = 400;
    localparam int NUM_VECTORS   = RESET_CYCLES + PRELOAD_WORDS + NUM_RANDOM;
    localparam int WATCHDOG_NS   = (NUM_VECTORS + 20) * CLK_PERIOD;
    localparam int unsigned SEED = 4062;

    logic                      clk = 1'b0;
    logic                      rst_n;
    mips_types_pkg::ex_mem_t   ex_mem;
    logic [5:0]                hw_int;
    mips_types_pkg::reg_addr_t cp0_raddr;
    mips_types_pkg::wb_t       wb;
    mips_cp0_pkg::excp_t       excp_type;
    mips_types_pkg::word_t     cp0_epc;
    mips_types_pkg::word_t     cp0_rdata;

    // Reference state. Random addresses stay inside the first PRELOAD_WORDS words.
    mips_types_pkg::word_t m_ram [0:PRELOAD_WORDS-1];
    mips_types_pkg::word_t m_status;
    mips_types_pkg::word_t m_cause;
    mips_types_pkg::word_t m_epc;
    mips_types_pkg::wb_t   m_wb;
    int num_checks = 0;
    int num_errors = 0;

    mem_subsystem u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .ex_mem_i    (ex_mem),
        .hw_int_i    (hw_int),
        .cp0_raddr_i (cp0_raddr),
        .wb_o        (wb),
        .excp_type_o (excp_type),
        .cp0_epc_o   (cp0_epc),
        .cp0_rdata_o (cp0_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_values(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("ERR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic mips_types_pkg::word_t read_model_cp0(input mips_types_pkg::reg_addr_t a);
        case (a)
            mips_cp0_pkg::CP0_STATUS: return m_status;
            mips_cp0_pkg::CP0_CAUSE:  return m_cause;
            mips_cp0_pkg::CP0_EPC:    return m_epc;
            default:                  return 32'd0;
        endcase
    endfunction

    // Interrupt first, then syscall, invalid instruction, overflow and eret.
    function automatic mips_cp0_pkg::excp_t pick_excp(input mips_types_pkg::word_t st,
                                                      input mips_types_pkg::word_t ca,
                                                      input mips_types_pkg::ex_mem_t v);
        logic [7:0] pend;
        pend = ca[15:8] & st[15:8];
        if (v.pc == mips_cp0_pkg::PC_RESET_ADDR) return mips_cp0_pkg::EXCP_NONE;
        if ((|pend) && !st[1] && st[0]) return mips_cp0_pkg::EXCP_INTERRUPT;
        if (v.excp_req[8]) return mips_cp0_pkg::EXCP_SYSCALL;
        if (v.excp_req[9]) return mips_cp0_pkg::EXCP_INVALID_INST;
        if (v.excp_req[11]) return mips_cp0_pkg::EXCP_OV;
        if (v.excp_req[12]) return mips_cp0_pkg::EXCP_ERET;
        return mips_cp0_pkg::EXCP_NONE;
    endfunction

    function automatic mips_types_pkg::word_t extend_load(input mips_types_pkg::oper_t op,
                                                          input mips_types_pkg::word_t w);
        case (op)
            mips_types_pkg::op_lb:  return {{24{w[7]}}, w[7:0]};
            mips_types_pkg::op_lbu: return {24'd0, w[7:0]};
            mips_types_pkg::op_lh:  return {{16{w[15]}}, w[15:0]};
            mips_types_pkg::op_lhu: return {16'd0, w[15:0]};
            default:                return w;
        endcase
    endfunction

    // Outputs that were registered at the last rising edge.
    task automatic check_registered();
        compare_values("wb_o.reg_we", 32'(wb.reg_we), 32'(m_wb.reg_we));
        compare_values("wb_o.reg_waddr", 32'(wb.reg_waddr), 32'(m_wb.reg_waddr));
        compare_values("wb_o.reg_wdata", wb.reg_wdata, m_wb.reg_wdata);
        compare_values("wb_o.hilo_we", 32'(wb.hilo_we), 32'(m_wb.hilo_we));
        compare_values("wb_o.hi", wb.hi, m_wb.hi);
        compare_values("wb_o.lo", wb.lo, m_wb.lo);
        compare_values("wb_o.cp0_we", 32'(wb.cp0_we), 32'(m_wb.cp0_we));
        compare_values("wb_o.cp0_waddr", 32'(wb.cp0_waddr), 32'(m_wb.cp0_waddr));
        compare_values("wb_o.cp0_wdata", wb.cp0_wdata, m_wb.cp0_wdata);
        compare_values("cp0_epc_o", cp0_epc, m_epc);
    endtask

    function automatic mips_types_pkg::reg_addr_t pick_cp0_addr();
        case ($urandom_range(0, 3))
            0:       return mips_cp0_pkg::CP0_STATUS;
            1:       return mips_cp0_pkg::CP0_CAUSE;
            2:       return mips_cp0_pkg::CP0_EPC;
            default: return 5'($urandom);
        endcase
    endfunction

    task automatic make_random_vector(output mips_types_pkg::ex_mem_t v, output logic [5:0] hw,
                                      output mips_types_pkg::reg_addr_t raddr);
        v              = '0;
        v.reg_we       = 1'($urandom);
        v.reg_waddr    = 5'($urandom);
        v.reg_wdata    = $urandom;
        v.hilo_we      = 1'($urandom);
        v.hi           = $urandom;
        v.lo           = $urandom;
        v.oper         = mips_types_pkg::oper_t'(4'($urandom_range(0, 8)));
        v.mem_addr     = $urandom & 32'h0000_003F;
        v.mem_wdata    = $urandom;
        v.cp0_we       = ($urandom_range(0, 3) == 0);
        v.cp0_waddr    = pick_cp0_addr();
        v.cp0_wdata    = $urandom;
        v.excp_req[8]  = ($urandom_range(0, 9) == 0);
        v.excp_req[9]  = ($urandom_range(0, 9) == 0);
        v.excp_req[11] = ($urandom_range(0, 9) == 0);
        v.excp_req[12] = ($urandom_range(0, 7) == 0);
        v.pc           = ($urandom_range(0, 7) == 0) ? mips_cp0_pkg::PC_RESET_ADDR
                                                     : ($urandom & 32'hFFFF_FFFC);
        v.in_delayslot = 1'($urandom);
        hw             = ($urandom_range(0, 3) == 0) ? 6'($urandom) : 6'd0;
        raddr          = pick_cp0_addr();
    endtask

    // Called at a falling edge and returns at the next one.
    task automatic run_vector(input mips_types_pkg::ex_mem_t vec, input logic [5:0] hw,
                              input mips_types_pkg::reg_addr_t raddr);
        mips_types_pkg::word_t n_status;
        mips_types_pkg::word_t n_cause;
        mips_types_pkg::word_t n_epc;
        mips_types_pkg::word_t new_word;
        mips_types_pkg::wb_t   n_wb;
        mips_cp0_pkg::excp_t   exp_excp;
        logic [3:0]            idx;
        logic                  squash;
        logic                  do_store;
        check_registered();
        ex_mem    = vec;
        hw_int    = hw;
        cp0_raddr = raddr;
        #1;
        compare_values("cp0_rdata_o", cp0_rdata, read_model_cp0(raddr));
        // A CP0 write still in writeback counts as already done.
        n_status = m_status;
        n_cause  = m_cause;
        n_epc    = m_epc;
        if (m_wb.cp0_we) begin
            case (m_wb.cp0_waddr)
                mips_cp0_pkg::CP0_STATUS: n_status = m_wb.cp0_wdata;
                mips_cp0_pkg::CP0_CAUSE: begin
                    n_cause = (m_cause & ~32'h300) | (m_wb.cp0_wdata & 32'h300);
                end
                mips_cp0_pkg::CP0_EPC:    n_epc = m_wb.cp0_wdata;
                default: ;
            endcase
        end
        exp_excp = pick_excp(n_status, n_cause, vec);
        compare_values("excp_type_o", excp_type, exp_excp);
        squash = (exp_excp != mips_cp0_pkg::EXCP_NONE);
        idx = vec.mem_addr[5:2];
        n_wb.reg_we    = vec.reg_we && !squash;
        n_wb.reg_waddr = vec.reg_waddr;
        n_wb.reg_wdata = vec.reg_wdata;
        if (vec.oper inside {mips_types_pkg::op_lb, mips_types_pkg::op_lbu, mips_types_pkg::op_lh,
                             mips_types_pkg::op_lhu, mips_types_pkg::op_lw}) begin
            n_wb.reg_wdata = extend_load(vec.oper, m_ram[idx]);
        end
        n_wb.hilo_we   = vec.hilo_we && !squash;
        n_wb.hi        = vec.hi;
        n_wb.lo        = vec.lo;
        n_wb.cp0_we    = vec.cp0_we && !squash;
        n_wb.cp0_waddr = vec.cp0_waddr;
        n_wb.cp0_wdata = vec.cp0_wdata;
        new_word = m_ram[idx];
        case (vec.oper)
            mips_types_pkg::op_sb: new_word[7:0] = vec.mem_wdata[7:0];
            mips_types_pkg::op_sh: new_word[15:0] = vec.mem_wdata[15:0];
            mips_types_pkg::op_sw: new_word = vec.mem_wdata;
            default: ;
        endcase
        do_store = !squash && (vec.oper inside {mips_types_pkg::op_sb, mips_types_pkg::op_sh,
                                                mips_types_pkg::op_sw});
        n_cause[15:10] = hw;
        if (squash && exp_excp != mips_cp0_pkg::EXCP_ERET) begin
            n_status[1]   = 1'b1;
            n_cause[6:2]  = exp_excp[4:0];
            n_cause[31]   = vec.in_delayslot;
            n_epc         = vec.in_delayslot ? vec.pc - 32'd4 : vec.pc;
        end else if (exp_excp == mips_cp0_pkg::EXCP_ERET) begin
            n_status[1] = 1'b0;
        end
        @(posedge clk);
        if (do_store) m_ram[idx] = new_word;
        m_status = n_status;
        m_cause  = n_cause;
        m_epc    = n_epc;
        m_wb     = n_wb;
        @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the test sequence finished.", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        mips_types_pkg::ex_mem_t vec;
        logic [5:0]              hw;
        mips_types_pkg::reg_addr_t raddr;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        ex_mem     = '0;
        ex_mem.pc  = mips_cp0_pkg::PC_RESET_ADDR;
        hw_int     = 6'd0;
        cp0_raddr  = mips_cp0_pkg::CP0_STATUS;
        m_status   = '0;
        m_cause    = '0;
        m_epc      = '0;
        m_wb       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Strobes and every CP0 register must come out of reset cleared.
        check_registered();
        for (int r = 12; r <= 14; r++) begin
            cp0_raddr = 5'(r);
            #1;
            compare_values("cp0_rdata_o", cp0_rdata, 32'd0);
        end
        @(negedge clk);
        // Bubble stores give every RAM word in use a known value.
        for (int i = 0; i < PRELOAD_WORDS; i++) begin
            vec           = '0;
            vec.oper      = mips_types_pkg::op_sw;
            vec.mem_addr  = 32'(i) << 2;
            vec.mem_wdata = $urandom;
            vec.pc        = mips_cp0_pkg::PC_RESET_ADDR;
            run_vector(vec, 6'd0, mips_cp0_pkg::CP0_STATUS);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            make_random_vector(vec, hw, raddr);
            run_vector(vec, hw, raddr);
        end
        check_registered();
        $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
mips_types_pkg.sv
mips_cp0_pkg.sv
mem_stage.sv
cp0_regs.sv
data_ram.sv
mem_wb_reg.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output.
verilator --binary --timing --assert -f sources.f --top-module tb_mem_subsystem -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "TEST RESULT: PASS" \
    && echo "Simulation run succeeded." \
    || { echo "Simulation run did not succeed."; exit 1; }
